//--- sim.f
verilog/mcu_bus_pkg.sv
verilog/bus_decoder.sv
verilog/word_ram.sv
verilog/interval_timer.sv
verilog/time_counter.sv
verilog/port_register.sv
verilog/read_mux.sv
verilog/mcu_periph_top.sv
verification/tb_mcu_periph.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, and look for the pass line.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_mcu_periph \
    -f sim.f \
    -o tb_mcu_periph \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/tb_mcu_periph 2>&1)"
echo "$sim_out"

grep -qxF "Done: no errors" <<< "$sim_out" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; exit 1; }

//--- verification/tb_mcu_periph.sv
`timescale 1ns/1ns

module tb_mcu_periph;
    import mcu_bus_pkg::*;

    localparam int WAIT_LIMIT = 1000;

    logic       clk;
    logic       rst_n;
    bus_addr_t  addr;
    bus_data_t  wdata;
    byte_wr_n_t wr_n;
    logic       rd_n;
    logic       irq_ack;
    logic       con_button;
    logic       psh_button;
    logic       tra;
    logic       trb;
    logic       bak_button;
    logic       scl_in;
    logic       sda_in;
    bus_data_t  rdata;
    logic       irq;
    logic       led;
    logic       scl;
    logic       sda;

    int          errors = 0;
    int unsigned cycle = 0;
    int unsigned last_strobe;

    logic       chk_rd;        // rdata is due at the next negedge.
    bus_data_t  exp_rdata;
    logic       chk_lines;     // irq and port lines watched every cycle.
    logic       exp_irq;
    logic [2:0] exp_port;

    bus_data_t ram_model [RAM_WORDS];
    ram_addr_t used_idx [8];

    mcu_periph_top u_mcu_periph_top (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wdata      (wdata),
        .wr_n       (wr_n),
        .rd_n       (rd_n),
        .irq_ack    (irq_ack),
        .con_button (con_button),
        .psh_button (psh_button),
        .tra        (tra),
        .trb        (trb),
        .bak_button (bak_button),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .rdata      (rdata),
        .irq        (irq),
        .led        (led),
        .scl        (scl),
        .sda        (sda)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;   // edge index.
    end

    rdata_on_read: assert property (@(negedge clk) chk_rd |-> rdata == exp_rdata)
        else begin
            errors = errors + 1;
            $display("mismatch rdata: got %h, expected %h", rdata, exp_rdata);
        end

    irq_level: assert property (@(negedge clk) chk_lines |-> irq == exp_irq)
        else begin
            errors = errors + 1;
            $display("mismatch irq: got %h, expected %h", irq, exp_irq);
        end

    port_lines: assert property (@(negedge clk) chk_lines |-> {led, scl, sda} == exp_port)
        else begin
            errors = errors + 1;
            $display("mismatch led/scl/sda: got %h, expected %h", {led, scl, sda}, exp_port);
        end

    function automatic bus_addr_t make_addr(input region_t region, input ram_addr_t idx);
        return {region, 14'h0, idx, 2'b00};
    endfunction

    // strobe is sampled at the edge after it is driven.
    task automatic write_bus(input bus_addr_t a, input bus_data_t d, input byte_wr_n_t lanes_n);
        @(posedge clk);
        addr <= a;
        wdata <= d;
        wr_n <= lanes_n;
        @(posedge clk);
        last_strobe = cycle;
        wr_n <= '1;
    endtask

    task automatic read_bus(input bus_addr_t a, input logic check, input bus_data_t exp,
                            output bus_data_t d);
        @(posedge clk);
        addr <= a;
        rd_n <= 1'b0;
        @(posedge clk);
        last_strobe = cycle;
        rd_n <= 1'b1;
        @(posedge clk);   // devices and mux update here.
        exp_rdata = exp;
        chk_rd = check;
        @(negedge clk);
        d = rdata;
        @(posedge clk);   // master sample edge.
        chk_rd = 1'b0;
    endtask

    task automatic check_ram();
        bus_data_t data;
        bus_data_t unused;
        int        pick;
        int        lane;
        for (int i = 0; i < 8; i++) begin
            used_idx[i] = ram_addr_t'($urandom);
            data = $urandom;
            write_bus(make_addr(REGION_RAM, used_idx[i]), data, 4'h0);
            ram_model[used_idx[i]] = data;
        end
        // single lanes over the full words.
        for (int i = 0; i < 16; i++) begin
            pick = $urandom % 8;
            lane = $urandom % 4;
            data = $urandom;
            write_bus(make_addr(REGION_RAM, used_idx[pick]), data, ~(4'b0001 << lane));
            ram_model[used_idx[pick]][8*lane +: 8] = data[8*lane +: 8];
        end
        for (int i = 0; i < 8; i++) begin
            read_bus(make_addr(REGION_RAM, used_idx[i]), 1'b1, ram_model[used_idx[i]], unused);
        end
    endtask

    task automatic check_ports();
        bus_data_t  data;
        bus_data_t  unused;
        logic [6:0] pins;
        for (int i = 0; i < 4; i++) begin
            data = $urandom;
            write_bus(make_addr(REGION_PORTS, '0), data, 4'b1110);
            @(posedge clk);
            exp_port = data[2:0];
        end
        // lane 0 not strobed, lines stay.
        write_bus(make_addr(REGION_PORTS, '0), {29'h0, ~exp_port}, 4'b0001);
        @(posedge clk);
        for (int i = 0; i < 3; i++) begin
            pins = 7'($urandom);
            @(posedge clk);
            {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} <= pins;
            read_bus(make_addr(REGION_PORTS, '0), 1'b1, {25'h0, pins}, unused);
        end
    endtask

    // expected irq follows the edge count, the loop ends once irq is seen.
    task automatic wait_for_irq(input usec_t v);
        int unsigned target;
        int          guard;
        write_bus(make_addr(REGION_TIMER, '0), v, 4'h0);
        target = last_strobe + 1 + v * US_CYCLES;
        guard = 0;
        do begin
            @(posedge clk);
            exp_irq = (cycle >= target);
            @(negedge clk);
            guard++;
        end while (!irq && guard < WAIT_LIMIT);
        if (!irq) begin
            errors = errors + 1;
            $display("timeout: timer of %0d us never raised irq", v);
        end
    endtask

    task automatic ack_irq();
        @(posedge clk);
        irq_ack <= 1'b1;
        @(posedge clk);
        irq_ack <= 1'b0;
        exp_irq = 1'b0;   // ack sampled at this edge.
        repeat (2) @(posedge clk);
    endtask

    task automatic check_time();
        bus_data_t   t0;
        bus_data_t   t1;
        int unsigned s0;
        int unsigned lo;
        int unsigned delta;
        int          gap;
        for (int i = 0; i < 4; i++) begin
            gap = $urandom % 40;
            read_bus(make_addr(REGION_TIME, '0), 1'b0, '0, t0);
            s0 = last_strobe;
            repeat (gap) @(posedge clk);
            read_bus(make_addr(REGION_TIME, '0), 1'b0, '0, t1);
            lo = (last_strobe - s0) / US_CYCLES;
            delta = t1 - t0;
            time_delta: assert (delta >= lo && delta <= lo + 1)
                else begin
                    errors = errors + 1;
                    $display("mismatch time delta: got %h, expected %h or %h", delta, lo, lo + 1);
                end
        end
    endtask

    task automatic check_unmapped();
        bus_data_t unused;
        read_bus(make_addr(5'h05, '0), 1'b1, '0, unused);
        read_bus(make_addr(REGION_TIMER, '0), 1'b1, '0, unused);   // timer has no read word.
        write_bus(make_addr(5'h03, used_idx[0]), ~ram_model[used_idx[0]], 4'h0);
        read_bus(make_addr(REGION_RAM, used_idx[0]), 1'b1, ram_model[used_idx[0]], unused);
    endtask

    initial begin
        void'($urandom(32'hdf330727));
        chk_rd = 1'b0;
        chk_lines = 1'b0;
        exp_rdata = '0;
        exp_irq = 1'b0;
        exp_port = 3'b111;
        rst_n <= 1'b0;
        addr <= '0;
        wdata <= '0;
        wr_n <= '1;
        rd_n <= 1'b1;
        irq_ack <= 1'b0;
        {con_button, psh_button, tra, trb, bak_button, scl_in, sda_in} <= 7'h7f;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        chk_lines = 1'b1;
        @(posedge clk);
        chk_rd = 1'b1;   // rdata still at reset value.
        @(posedge clk);
        chk_rd = 1'b0;

        check_ram();
        check_ports();
        wait_for_irq(3);
        ack_irq();
        wait_for_irq(1);
        // zero load clears the pending irq and stops the timer.
        write_bus(make_addr(REGION_TIMER, '0), '0, 4'h0);
        @(posedge clk);
        exp_irq = 1'b0;
        repeat (5 * US_CYCLES) @(posedge clk);
        check_time();
        check_unmapped();
        repeat (2) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/mcu_periph_top.sv
`timescale 1ns/1ns

module mcu_periph_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mcu_bus_pkg::bus_addr_t  addr,
    input  mcu_bus_pkg::bus_data_t  wdata,
    input  mcu_bus_pkg::byte_wr_n_t wr_n,
    input  logic                   rd_n,
    input  logic                   irq_ack,
    input  logic                   con_button,
    input  logic                   psh_button,
    input  logic                   tra,
    input  logic                   trb,
    input  logic                   bak_button,
    input  logic                   scl_in,
    input  logic                   sda_in,
    output mcu_bus_pkg::bus_data_t  rdata,
    output logic                   irq,
    output logic                   led,
    output logic                   scl,
    output logic                   sda
);
    import mcu_bus_pkg::*;

    bus_req_t  req;
    dev_sel_t  sel;
    bus_data_t ram_rdata;
    bus_data_t time_rdata;
    bus_data_t port_rdata;

    bus_decoder u_bus_decoder (
        .clk   (clk),
        .rst_n (rst_n),
        .addr  (addr),
        .wdata (wdata),
        .wr_n  (wr_n),
        .rd_n  (rd_n),
        .req   (req),
        .sel   (sel)
    );

    word_ram u_word_ram (
        .clk     (clk),
        .req     (req),
        .sel_ram (sel.ram),
        .rdata   (ram_rdata)
    );

    interval_timer u_interval_timer (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .sel_timer (sel.timer),
        .irq_ack   (irq_ack),
        .irq       (irq)
    );

    time_counter u_time_counter (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel_time (sel.time_ctr),
        .rd_n_q   (req.rd_n),
        .rdata    (time_rdata)
    );

    port_register u_port_register (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .sel_ports  (sel.ports),
        .con_button (con_button),
        .psh_button (psh_button),
        .tra        (tra),
        .trb        (trb),
        .bak_button (bak_button),
        .scl_in     (scl_in),
        .sda_in     (sda_in),
        .led        (led),
        .scl        (scl),
        .sda        (sda),
        .rdata      (port_rdata)
    );

    read_mux u_read_mux (
        .clk        (clk),
        .rst_n      (rst_n),
        .sel        (sel),
        .ram_rdata  (ram_rdata),
        .time_rdata (time_rdata),
        .port_rdata (port_rdata),
        .rdata      (rdata)
    );

endmodule

//--- verilog/read_mux.sv
`timescale 1ns/1ns

module read_mux (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mcu_bus_pkg::dev_sel_t   sel,
    input  mcu_bus_pkg::bus_data_t  ram_rdata,
    input  mcu_bus_pkg::bus_data_t  time_rdata,
    input  mcu_bus_pkg::bus_data_t  port_rdata,
    output mcu_bus_pkg::bus_data_t  rdata
);
    import mcu_bus_pkg::*;

    region_t region_q;

    // lines up with the device read registers.
    // reset lands on region 0, which reads zero.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            region_q <= '0;
        end else begin
            region_q <= sel.region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_RAM:   rdata = ram_rdata;
            REGION_TIME:  rdata = time_rdata;
            REGION_PORTS: rdata = port_rdata;
            default:      rdata = '0;   // timer and unmapped.
        endcase
    end

endmodule

//--- verilog/port_register.sv
`timescale 1ns/1ns

module port_register (
    input  logic                  clk,
    input  logic                  rst_n,
    input  mcu_bus_pkg::bus_req_t  req,
    input  logic                  sel_ports,
    input  logic                  con_button,
    input  logic                  psh_button,
    input  logic                  tra,          // encoder.
    input  logic                  trb,          // encoder.
    input  logic                  bak_button,
    input  logic                  scl_in,
    input  logic                  sda_in,
    output logic                  led,
    output logic                  scl,
    output logic                  sda,
    output mcu_bus_pkg::bus_data_t rdata
);
    import mcu_bus_pkg::*;

    // lines idle high, i2c released.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            led <= 1'b1;
            scl <= 1'b1;
            sda <= 1'b1;
        end else if (sel_ports && !req.wr_n[0]) begin
            {led, scl, sda} <= req.wdata[2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (sel_ports && !req.rd_n) begin
            rdata <= {25'b0, con_button, psh_button, tra, trb, bak_button,
                      scl_in, sda_in};
        end
    end

endmodule

//--- verilog/time_counter.sv
`timescale 1ns/1ns

module time_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sel_time,
    input  logic                  rd_n_q,
    output mcu_bus_pkg::bus_data_t rdata
);
    import mcu_bus_pkg::*;

    presc_t presc;
    usec_t  usec;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
            usec <= '0;
        end else if (presc == PRESC_LAST) begin
            presc <= '0;
            usec <= usec + 1'b1;   // wraps after about 71 minutes.
        end else begin
            presc <= presc + 1'b1;
        end
    end

    // snapshot on read.
    always_ff @(posedge clk) begin
        if (sel_time && !rd_n_q) begin
            rdata <= usec;
        end
    end

endmodule

//--- verilog/interval_timer.sv
`timescale 1ns/1ns

module interval_timer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mcu_bus_pkg::bus_req_t req,
    input  logic                 sel_timer,
    input  logic                 irq_ack,
    output logic                 irq
);
    import mcu_bus_pkg::*;

    presc_t presc;
    usec_t  remaining;
    logic   load;
    logic   tick;

    assign load = sel_timer && ~&req.wr_n;
    assign tick = (presc == PRESC_LAST);

    // prescaler restarts on every load so the first tick is a full microsecond.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc <= '0;
        end else if (load || tick) begin
            presc <= '0;
        end else begin
            presc <= presc + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
            irq <= 1'b0;
        end else if (load) begin
            remaining <= req.wdata;   // zero stops the timer.
            irq <= 1'b0;
        end else if (tick && remaining != '0) begin
            remaining <= remaining - 1'b1;
            if (remaining == usec_t'(1)) begin
                irq <= 1'b1;
            end
        end else if (irq_ack) begin
            irq <= 1'b0;
        end
    end

endmodule

//--- verilog/word_ram.sv
`timescale 1ns/1ns

module word_ram (
    input  logic                  clk,
    input  mcu_bus_pkg::bus_req_t  req,
    input  logic                  sel_ram,
    output mcu_bus_pkg::bus_data_t rdata
);
    import mcu_bus_pkg::*;

    // four byte lanes per word.
    logic [3:0][7:0] mem [RAM_WORDS];

    ram_addr_t word_addr;

    assign word_addr = req.addr[RAM_WORD_BITS+1:2];

    always_ff @(posedge clk) begin
        if (sel_ram) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (!req.wr_n[lane]) begin
                    mem[word_addr][lane] <= req.wdata[8*lane +: 8];
                end
            end
        end
    end

    // read word only moves on a read, so rdata holds across writes.
    always_ff @(posedge clk) begin
        if (sel_ram && !req.rd_n) begin
            rdata <= mem[word_addr];   // old content.
        end
    end

endmodule

//--- verilog/bus_decoder.sv
`timescale 1ns/1ns

module bus_decoder (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mcu_bus_pkg::bus_addr_t  addr,
    input  mcu_bus_pkg::bus_data_t  wdata,
    input  mcu_bus_pkg::byte_wr_n_t wr_n,
    input  logic                   rd_n,
    output mcu_bus_pkg::bus_req_t   req,
    output mcu_bus_pkg::dev_sel_t   sel
);
    import mcu_bus_pkg::*;

    region_t region;
    logic    active;

    assign region = addr[REGION_MSB:REGION_LSB];
    assign active = ~&wr_n | ~rd_n;   // any strobe low.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req <= '{addr: '0, wdata: '0, wr_n: '1, rd_n: 1'b1};
        end else begin
            req <= '{addr: addr, wdata: wdata, wr_n: wr_n, rd_n: rd_n};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sel <= '0;
        end else begin
            sel.ram      <= active && (region == REGION_RAM);
            sel.time_ctr <= active && (region == REGION_TIME);
            sel.timer    <= active && (region == REGION_TIMER);
            sel.ports    <= active && (region == REGION_PORTS);
            // the read mux follows the last read only.
            if (!rd_n) begin
                sel.region <= region;
            end
        end
    end

endmodule

//--- verilog/mcu_bus_pkg.sv
package mcu_bus_pkg;

    // bus widths.
    typedef logic [31:0] bus_addr_t;
    typedef logic [31:0] bus_data_t;
    typedef logic [3:0] byte_wr_n_t;   // one active-low strobe per byte lane.
    typedef logic [4:0] region_t;
    typedef logic [31:0] usec_t;

    // the region code sits in the top address bits.
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 27;

    localparam region_t REGION_RAM = 5'h02;
    localparam region_t REGION_TIME = 5'h1b;
    localparam region_t REGION_TIMER = 5'h1c;
    localparam region_t REGION_PORTS = 5'h1f;

    // 2k words of RAM.
    localparam int RAM_WORD_BITS = 11;
    localparam int RAM_WORDS = 1 << RAM_WORD_BITS;

    typedef logic [RAM_WORD_BITS-1:0] ram_addr_t;

    // clk cycles per microsecond tick.
    localparam int US_CYCLES = 8;
    localparam int PRESC_BITS = $clog2(US_CYCLES);

    typedef logic [PRESC_BITS-1:0] presc_t;

    localparam presc_t PRESC_LAST = presc_t'(US_CYCLES - 1);

    // registered request as seen by the devices.
    typedef struct packed {
        bus_addr_t addr;
        bus_data_t wdata;
        byte_wr_n_t wr_n;
        logic rd_n;
    } bus_req_t;

    // strobe-qualified device selects.
    // region holds the region of the most recent read.
    typedef struct packed {
        logic ram;
        logic time_ctr;
        logic timer;
        logic ports;
        region_t region;
    } dev_sel_t;

endpackage
